// File: Makefile
# Verilator simulation of the image port

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ninjin_image_port \
		-f src.f -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: ninjin_image_buffer.sv
`timescale 1ns/1ns

module ninjin_image_buffer (
  input  logic                           clk,
  input  logic                           ddr_we,
  input  logic [ninjin_pkg::MEMSIZE-1:0] ddr_waddr,
  input  logic [ninjin_pkg::DWIDTH-1:0]  ddr_wdata,
  input  logic [ninjin_pkg::MEMSIZE-1:0] ddr_raddr,
  output logic [ninjin_pkg::DWIDTH-1:0]  ddr_rdata,
  input  logic                           ext_we,
  input  logic [ninjin_pkg::MEMSIZE-1:0] ext_addr,
  input  logic [ninjin_pkg::DWIDTH-1:0]  ext_wdata,
  output logic [ninjin_pkg::DWIDTH-1:0]  ext_rdata
);

  import ninjin_pkg::*;

  logic [DWIDTH-1:0] mem [0:2**MEMSIZE-1];
  logic              ext_blocked;

  // dma side wins a same-word write
  assign ext_blocked = ddr_we && ddr_waddr == ext_addr;

  // ========================================
  // write ports
  // ========================================

  always_ff @(posedge clk) begin
    if (ddr_we) begin
      mem[ddr_waddr] <= ddr_wdata;
    end
    if (ext_we && !ext_blocked) begin
      mem[ext_addr] <= ext_wdata;
    end
  end

  // ========================================
  // read ports, one cycle latency
  // ========================================

  always_ff @(posedge clk) begin
    ddr_rdata <= mem[ddr_raddr];
    ext_rdata <= mem[ext_addr];
  end

endmodule

// File: ninjin_image_port.sv
`timescale 1ns/1ns

module ninjin_image_port (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           req,
  input  logic                           mode,
  input  logic [ninjin_pkg::AWIDTH-1:0]  host_addr,
  input  logic [ninjin_pkg::MEMSIZE-1:0] buf_base,
  output logic                           busy,
  output logic [2:0]                     err,
  output logic                           awvalid,
  input  logic                           awready,
  output logic [ninjin_pkg::AWIDTH-1:0]  awaddr,
  output logic                           wvalid,
  input  logic                           wready,
  output logic [ninjin_pkg::DWIDTH-1:0]  wdata,
  output logic                           wlast,
  input  logic                           bvalid,
  output logic                           bready,
  input  logic [1:0]                     bresp,
  output logic                           arvalid,
  input  logic                           arready,
  output logic [ninjin_pkg::AWIDTH-1:0]  araddr,
  input  logic                           rvalid,
  output logic                           rready,
  input  logic [ninjin_pkg::DWIDTH-1:0]  rdata,
  input  logic [1:0]                     rresp,
  input  logic                           rlast,
  input  logic                           ext_we,
  input  logic [ninjin_pkg::MEMSIZE-1:0] ext_addr,
  input  logic [ninjin_pkg::DWIDTH-1:0]  ext_wdata,
  output logic [ninjin_pkg::DWIDTH-1:0]  ext_rdata
);

  import ninjin_pkg::*;

  // dma port between master and buffer
  logic               ddr_we;
  logic [MEMSIZE-1:0] ddr_waddr;
  logic [DWIDTH-1:0]  ddr_wdata;
  logic [MEMSIZE-1:0] ddr_raddr;
  logic [DWIDTH-1:0]  ddr_rdata;

  ninjin_m_axi_image m_axi_image_i (
    .clk       (clk),
    .xrst      (xrst),
    .req       (req),
    .mode      (mode),
    .host_addr (host_addr),
    .buf_base  (buf_base),
    .busy      (busy),
    .err       (err),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wlast     (wlast),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rlast     (rlast),
    .ddr_rdata (ddr_rdata),
    .ddr_we    (ddr_we),
    .ddr_waddr (ddr_waddr),
    .ddr_wdata (ddr_wdata),
    .ddr_raddr (ddr_raddr)
  );

  // host side reaches the buffer directly
  ninjin_image_buffer image_buffer_i (
    .clk       (clk),
    .ddr_we    (ddr_we),
    .ddr_waddr (ddr_waddr),
    .ddr_wdata (ddr_wdata),
    .ddr_raddr (ddr_raddr),
    .ddr_rdata (ddr_rdata),
    .ext_we    (ext_we),
    .ext_addr  (ext_addr),
    .ext_wdata (ext_wdata),
    .ext_rdata (ext_rdata)
  );

endmodule

// File: ninjin_m_axi_image.sv
`timescale 1ns/1ns

module ninjin_m_axi_image (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           req,
  input  logic                           mode,
  input  logic [ninjin_pkg::AWIDTH-1:0]  host_addr,
  input  logic [ninjin_pkg::MEMSIZE-1:0] buf_base,
  output logic                           busy,
  output logic [2:0]                     err,
  output logic                           awvalid,
  input  logic                           awready,
  output logic [ninjin_pkg::AWIDTH-1:0]  awaddr,
  output logic                           wvalid,
  input  logic                           wready,
  output logic [ninjin_pkg::DWIDTH-1:0]  wdata,
  output logic                           wlast,
  input  logic                           bvalid,
  output logic                           bready,
  input  logic [1:0]                     bresp,
  output logic                           arvalid,
  input  logic                           arready,
  output logic [ninjin_pkg::AWIDTH-1:0]  araddr,
  input  logic                           rvalid,
  output logic                           rready,
  input  logic [ninjin_pkg::DWIDTH-1:0]  rdata,
  input  logic [1:0]                     rresp,
  input  logic                           rlast,
  input  logic [ninjin_pkg::DWIDTH-1:0]  ddr_rdata,
  output logic                           ddr_we,
  output logic [ninjin_pkg::MEMSIZE-1:0] ddr_waddr,
  output logic [ninjin_pkg::DWIDTH-1:0]  ddr_wdata,
  output logic [ninjin_pkg::MEMSIZE-1:0] ddr_raddr
);

  import ninjin_pkg::*;

  logic                  req_d;
  logic                  req_pulse;
  logic                  start;
  logic                  wreq_pulse;
  logic                  rreq_pulse;
  logic                  mode_q;
  logic                  state_write;
  logic                  state_read;
  logic                  wstart;
  logic                  rstart;
  logic                  write_end;
  logic                  read_end;
  logic                  awnext;
  logic                  wnext;
  logic                  arnext;
  logic                  rnext;
  logic                  err_wresp;
  logic                  err_rresp;
  logic [BEAT_WIDTH-1:0] widx;
  logic [MEMSIZE-1:0]    raddr_q;
  logic [MEMSIZE-1:0]    raddr_next;

  // ========================================
  // core control
  // ========================================

  // rising edge of req, dropped while a burst runs
  assign req_pulse  = req && !req_d;
  assign start      = req_pulse && !busy;
  assign wreq_pulse = start && mode == DDR_WRITE;
  assign rreq_pulse = start && mode == DDR_READ;

  assign write_end = bvalid && bready;
  assign read_end  = rnext && rlast;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_d <= 1'b0;
    end else begin
      req_d <= req;
    end
  end

  // write channel, one start pulse per request
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state_write <= S_IDLE;
      wstart      <= 1'b0;
    end else begin
      wstart <= 1'b0;
      case (state_write)
        S_IDLE: begin
          if (wreq_pulse) begin
            state_write <= S_BUSY;
            wstart      <= 1'b1;
          end
        end
        S_BUSY: begin
          if (write_end) begin
            state_write <= S_IDLE;
          end
        end
      endcase
    end
  end

  // read channel runs on its own
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state_read <= S_IDLE;
      rstart     <= 1'b0;
    end else begin
      rstart <= 1'b0;
      case (state_read)
        S_IDLE: begin
          if (rreq_pulse) begin
            state_read <= S_BUSY;
            rstart     <= 1'b1;
          end
        end
        S_BUSY: begin
          if (read_end) begin
            state_read <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy   <= 1'b0;
      mode_q <= DDR_READ;
    end else if (start) begin
      busy   <= 1'b1;
      mode_q <= mode;
    end else if (busy && (mode_q == DDR_WRITE ? write_end : read_end)) begin
      busy <= 1'b0;
    end
  end

  // ========================================
  // write address
  // ========================================

  assign awnext = awvalid && awready;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      awvalid <= 1'b0;
    end else if (wstart) begin
      awvalid <= 1'b1;
    end else if (awnext) begin
      awvalid <= 1'b0;
    end
  end

  // points at the next burst once accepted
  always_ff @(posedge clk) begin
    if (wreq_pulse) begin
      awaddr <= host_addr;
    end else if (awnext) begin
      awaddr <= awaddr + AWIDTH'(BURST_BYTES);
    end
  end

  // ========================================
  // write data
  // ========================================

  assign wnext = wvalid && wready;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wvalid <= 1'b0;
    end else if (wstart) begin
      wvalid <= 1'b1;
    end else if (wnext && wlast) begin
      wvalid <= 1'b0;
    end
  end

  // buffer word already fetched, held under back-pressure
  always_ff @(posedge clk) begin
    if (wstart || wnext) begin
      wdata <= ddr_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      widx  <= '0;
      wlast <= 1'b0;
    end else if (wstart) begin
      widx  <= '0;
      wlast <= 1'b0;
    end else if (wnext) begin
      widx  <= widx + 1'b1;
      wlast <= !wlast && widx == BEAT_WIDTH'(BURST_LEN - 2);
    end
  end

  // ========================================
  // write response
  // ========================================

  assign err_wresp = write_end && bresp[1];

  // one cycle pulse after bvalid is seen
  always_ff @(posedge clk) begin
    if (!xrst) begin
      bready <= 1'b0;
    end else if (bready) begin
      bready <= 1'b0;
    end else if (bvalid && state_write == S_BUSY) begin
      bready <= 1'b1;
    end
  end

  // ========================================
  // read address
  // ========================================

  assign arnext = arvalid && arready;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      arvalid <= 1'b0;
    end else if (rstart) begin
      arvalid <= 1'b1;
    end else if (arnext) begin
      arvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rreq_pulse) begin
      araddr <= host_addr;
    end else if (arnext) begin
      araddr <= araddr + AWIDTH'(BURST_BYTES);
    end
  end

  // ========================================
  // read data
  // ========================================

  assign rnext     = rvalid && rready;
  assign err_rresp = rnext && rresp[1];

  // open from the accepted address until the last beat
  always_ff @(posedge clk) begin
    if (!xrst) begin
      rready <= 1'b0;
    end else if (arnext) begin
      rready <= 1'b1;
    end else if (read_end) begin
      rready <= 1'b0;
    end
  end

  // ========================================
  // memory control
  // ========================================

  // every accepted beat lands in the buffer at once
  assign ddr_we    = rnext;
  assign ddr_wdata = rdata;

  always_ff @(posedge clk) begin
    if (rreq_pulse) begin
      ddr_waddr <= buf_base;
    end else if (rnext) begin
      ddr_waddr <= ddr_waddr + 1'b1;
    end
  end

  // read address runs one word ahead of wdata
  assign raddr_next = start ? buf_base
                    : (wstart || wnext) ? raddr_q + 1'b1
                    : raddr_q;
  assign ddr_raddr  = raddr_next;

  always_ff @(posedge clk) begin
    raddr_q <= raddr_next;
  end

  // sticky until the next request
  always_ff @(posedge clk) begin
    if (!xrst) begin
      err <= '0;
    end else if (start) begin
      err <= '0;
    end else if (err_wresp || err_rresp) begin
      err[ERR_ANY]   <= 1'b1;
      err[ERR_WRESP] <= err[ERR_WRESP] | err_wresp;
      err[ERR_RRESP] <= err[ERR_RRESP] | err_rresp;
    end
  end

endmodule

// File: ninjin_pkg.sv
package ninjin_pkg;

  // ========================================
  // data path sizes
  // ========================================

  // one data word on the bus and in the buffer
  localparam int DWIDTH = 32;

  // host byte address
  localparam int AWIDTH = 32;

  // buffer word address width, 1024 words
  localparam int MEMSIZE = 10;

  // beats per burst and the beat counter width
  localparam int BURST_LEN  = 16;
  localparam int BEAT_WIDTH = $clog2(BURST_LEN);

  // host address span of one burst
  localparam int BURST_BYTES = BURST_LEN * DWIDTH / 8;

  // ========================================
  // mode and status encodings
  // ========================================

  // host to buffer
  localparam logic DDR_READ  = 1'b0;
  // buffer to host
  localparam logic DDR_WRITE = 1'b1;

  // bit positions within err
  localparam int ERR_ANY   = 0;
  localparam int ERR_RRESP = 1;
  localparam int ERR_WRESP = 2;

  // channel state machine
  localparam logic S_IDLE = 1'b0;
  localparam logic S_BUSY = 1'b1;

endpackage

// File: src.f
ninjin_pkg.sv
ninjin_image_buffer.sv
ninjin_m_axi_image.sv
ninjin_image_port.sv
tb_clock_gen.sv
tb_axi_host_mem.sv
tb_ninjin_assertions.sv
tb_ninjin_image_port.sv

// File: tb_axi_host_mem.sv
`timescale 1ns/1ns

module tb_axi_host_mem (
  input  logic                              clk,
  input  logic                              xrst,
  input  logic [4:0]                        stall,
  input  logic                              wr_err,
  input  logic                              rd_err_en,
  input  logic [ninjin_pkg::BEAT_WIDTH-1:0] rd_err_beat,
  input  logic                              load_we,
  input  logic [11:0]                       load_addr,
  input  logic [ninjin_pkg::DWIDTH-1:0]     load_data,
  input  logic [11:0]                       peek_addr,
  output logic [ninjin_pkg::DWIDTH-1:0]     peek_data,
  output int                                aw_count,
  output int                                ar_count,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [ninjin_pkg::AWIDTH-1:0]     awaddr,
  input  logic                              wvalid,
  output logic                              wready,
  input  logic [ninjin_pkg::DWIDTH-1:0]     wdata,
  input  logic                              wlast,
  output logic                              bvalid,
  input  logic                              bready,
  output logic [1:0]                        bresp,
  input  logic                              arvalid,
  output logic                              arready,
  input  logic [ninjin_pkg::AWIDTH-1:0]     araddr,
  output logic                              rvalid,
  input  logic                              rready,
  output logic [ninjin_pkg::DWIDTH-1:0]     rdata,
  output logic [1:0]                        rresp,
  output logic                              rlast
);

  import ninjin_pkg::*;

  // 4096 words of host memory
  logic [DWIDTH-1:0]     mem [0:4095];
  logic                  aw_held;
  logic                  resp_pending;
  logic [11:0]           widx;
  logic                  ar_held;
  logic [11:0]           ridx;
  logic [BEAT_WIDTH-1:0] rbeat;

  // stall bits: aw, w, ar, r, b
  assign awready = !aw_held && !stall[0];
  assign wready  = aw_held && !stall[1];
  assign arready = !ar_held && !stall[2];

  assign peek_data = mem[peek_addr];
  assign rdata     = mem[ridx];
  assign rlast     = rbeat == BEAT_WIDTH'(BURST_LEN - 1);
  assign rresp     = (rd_err_en && rbeat == rd_err_beat) ? 2'b10 : 2'b00;

  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_data;
    end
    if (wvalid && wready) begin
      mem[widx] <= wdata;
    end
  end

  // ========================================
  // write side
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      aw_held      <= 1'b0;
      resp_pending <= 1'b0;
      widx         <= '0;
      bvalid       <= 1'b0;
      bresp        <= 2'b00;
      aw_count     <= 0;
    end else begin
      if (awvalid && awready) begin
        aw_held  <= 1'b1;
        widx     <= awaddr[13:2];
        aw_count <= aw_count + 1;
      end
      if (wvalid && wready) begin
        widx <= widx + 12'd1;
        if (wlast) begin
          aw_held      <= 1'b0;
          resp_pending <= 1'b1;
        end
      end
      // response held until bready
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (resp_pending && !bvalid && !stall[4]) begin
        bvalid       <= 1'b1;
        bresp        <= wr_err ? 2'b10 : 2'b00;
        resp_pending <= 1'b0;
      end
    end
  end

  // ========================================
  // read side
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ar_held  <= 1'b0;
      ridx     <= '0;
      rbeat    <= '0;
      rvalid   <= 1'b0;
      ar_count <= 0;
    end else begin
      if (arvalid && arready) begin
        ar_held  <= 1'b1;
        ridx     <= araddr[13:2];
        rbeat    <= '0;
        ar_count <= ar_count + 1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        ridx   <= ridx + 12'd1;
        rbeat  <= rbeat + 1'b1;
        if (rlast) begin
          ar_held <= 1'b0;
        end
      end else if (ar_held && !rvalid && !stall[3]) begin
        rvalid <= 1'b1;
      end
    end
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic xrst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held for 5 cycles, released on a falling edge
  initial begin
    xrst = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
  end

endmodule

// File: tb_ninjin_assertions.sv
`timescale 1ns/1ns

module tb_ninjin_assertions (
  input logic                          clk,
  input logic                          xrst,
  input logic                          busy,
  input logic                          awvalid,
  input logic                          awready,
  input logic [ninjin_pkg::AWIDTH-1:0] awaddr,
  input logic                          wvalid,
  input logic                          wready,
  input logic [ninjin_pkg::DWIDTH-1:0] wdata,
  input logic                          wlast,
  input logic                          bready,
  input logic                          arvalid,
  input logic                          arready,
  input logic [ninjin_pkg::AWIDTH-1:0] araddr
);

  import ninjin_pkg::*;

  int                  fail_count = 0;
  logic [BEAT_WIDTH:0] wbeats;

  // W handshakes seen in the current burst
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wbeats <= '0;
    end else if (wvalid && wready) begin
      wbeats <= wlast ? '0 : wbeats + 1'b1;
    end
  end

  // ========================================
  // valid and payload hold until ready
  // ========================================

  aw_hold: assert property (@(posedge clk) disable iff (!xrst)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      $error("awvalid dropped or awaddr moved before awready");
      fail_count++;
    end

  w_hold: assert property (@(posedge clk) disable iff (!xrst)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else begin
      $error("wvalid dropped or W payload moved before wready");
      fail_count++;
    end

  ar_hold: assert property (@(posedge clk) disable iff (!xrst)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("arvalid dropped or araddr moved before arready");
      fail_count++;
    end

  // ========================================
  // burst framing
  // ========================================

  wlast_beat: assert property (@(posedge clk) disable iff (!xrst)
    wvalid && wready |-> wlast == (wbeats == (BEAT_WIDTH + 1)'(BURST_LEN - 1)))
    else begin
      $error("wlast not on the last beat of the burst");
      fail_count++;
    end

  bready_pulse: assert property (@(posedge clk) disable iff (!xrst)
    bready |=> !bready)
    else begin
      $error("bready held for more than one cycle");
      fail_count++;
    end

  aw_when_busy: assert property (@(posedge clk) disable iff (!xrst)
    $rose(awvalid) |-> busy)
    else begin
      $error("awvalid raised while idle");
      fail_count++;
    end

  ar_when_busy: assert property (@(posedge clk) disable iff (!xrst)
    $rose(arvalid) |-> busy)
    else begin
      $error("arvalid raised while idle");
      fail_count++;
    end

endmodule

bind ninjin_m_axi_image tb_ninjin_assertions assertions_i (
  .clk     (clk),
  .xrst    (xrst),
  .busy    (busy),
  .awvalid (awvalid),
  .awready (awready),
  .awaddr  (awaddr),
  .wvalid  (wvalid),
  .wready  (wready),
  .wdata   (wdata),
  .wlast   (wlast),
  .bready  (bready),
  .arvalid (arvalid),
  .arready (arready),
  .araddr  (araddr)
);

// File: tb_ninjin_image_port.sv
`timescale 1ns/1ns

module tb_ninjin_image_port;

  import ninjin_pkg::*;

  logic                  clk;
  logic                  xrst;
  logic                  req;
  logic                  mode;
  logic [AWIDTH-1:0]     host_addr;
  logic [MEMSIZE-1:0]    buf_base;
  logic                  busy;
  logic [2:0]            err;
  logic                  awvalid;
  logic                  awready;
  logic [AWIDTH-1:0]     awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [DWIDTH-1:0]     wdata;
  logic                  wlast;
  logic                  bvalid;
  logic                  bready;
  logic [1:0]            bresp;
  logic                  arvalid;
  logic                  arready;
  logic [AWIDTH-1:0]     araddr;
  logic                  rvalid;
  logic                  rready;
  logic [DWIDTH-1:0]     rdata;
  logic [1:0]            rresp;
  logic                  rlast;
  logic                  ext_we;
  logic [MEMSIZE-1:0]    ext_addr;
  logic [DWIDTH-1:0]     ext_wdata;
  logic [DWIDTH-1:0]     ext_rdata;
  // slave model control
  logic [4:0]            stall = '0;
  logic                  stall_en;
  logic                  wr_err;
  logic                  rd_err_en;
  logic [BEAT_WIDTH-1:0] rd_err_beat;
  logic                  load_we;
  logic [11:0]           load_addr;
  logic [DWIDTH-1:0]     load_data;
  logic [11:0]           peek_addr;
  logic [DWIDTH-1:0]     peek_data;
  int                    aw_count;
  int                    ar_count;
  int                    assert_fails;
  logic [31:0]           lfsr;
  int                    errors;
  int                    tests;
  int                    failed_tests;

  tb_clock_gen clock_gen_i (.*);
  ninjin_image_port dut_i (.*);
  tb_axi_host_mem host_mem_i (.*);

  assign assert_fails = dut_i.m_axi_image_i.assertions_i.fail_count;

  // ========================================
  // random numbers
  // ========================================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input logic [11:0] a);
    return {4'hd, a, 4'h5, a ^ 12'h9a3};
  endfunction

  always @(negedge clk) begin
    if (stall_en) begin
      stall = 5'(rand_bits(5));
    end else begin
      stall = '0;
    end
  end

  // ========================================
  // helper tasks
  // ========================================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic write_buffer(input logic [MEMSIZE-1:0] a, input logic [31:0] d);
    @(negedge clk);
    ext_we    = 1'b1;
    ext_addr  = a;
    ext_wdata = d;
    @(negedge clk);
    ext_we = 1'b0;
  endtask

  // registered read takes one cycle
  task automatic read_buffer(input logic [MEMSIZE-1:0] a, output logic [31:0] d);
    @(negedge clk);
    ext_addr = a;
    @(negedge clk);
    d = ext_rdata;
  endtask

  task automatic load_host(input logic [11:0] a, input logic [31:0] d);
    @(negedge clk);
    load_we   = 1'b1;
    load_addr = a;
    load_data = d;
    @(negedge clk);
    load_we = 1'b0;
  endtask

  task automatic peek_host(input logic [11:0] a, output logic [31:0] d);
    @(negedge clk);
    peek_addr = a;
    #1;
    d = peek_data;
  endtask

  task automatic check_untouched(input logic [11:0] a);
    logic [31:0] got;
    peek_host(a, got);
    check_value($sformatf("host_mem[%0d]", a), got, fill_word(a));
  endtask

  // request and wait for busy to rise and fall
  // toggle pokes req while busy
  task automatic run_burst(input logic m, input logic [AWIDTH-1:0] haddr,
                           input logic [MEMSIZE-1:0] base, input bit toggle);
    int n;
    @(negedge clk);
    mode      = m;
    host_addr = haddr;
    buf_base  = base;
    req       = 1'b1;
    @(negedge clk);
    req = 1'b0;
    // a second burst would land in the next region
    if (toggle) begin
      host_addr = haddr + AWIDTH'(BURST_BYTES);
      buf_base  = base + MEMSIZE'(BURST_LEN);
    end
    n = 0;
    while (busy !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (busy !== 1'b1) begin
      $display("Timeout: busy did not rise after the request");
      errors++;
    end
    n = 0;
    while (busy === 1'b1 && n < 2000) begin
      if (toggle) begin
        req = !req;
      end
      @(negedge clk);
      n++;
    end
    req = 1'b0;
    if (busy === 1'b1) begin
      $display("Timeout: busy did not fall within 2000 cycles");
      errors++;
    end
  endtask

  task automatic write_test(input logic [AWIDTH-1:0] haddr, input logic [MEMSIZE-1:0] base,
                            input logic [2:0] exp_err, input bit toggle);
    logic [31:0] words [BURST_LEN];
    logic [31:0] got;
    for (int k = 0; k < BURST_LEN; k++) begin
      words[k] = rand_bits(32);
      write_buffer(base + MEMSIZE'(k), words[k]);
    end
    run_burst(DDR_WRITE, haddr, base, toggle);
    for (int k = 0; k < BURST_LEN; k++) begin
      peek_host(haddr[13:2] + 12'(k), got);
      check_value($sformatf("host_mem[%0d]", haddr[13:2] + 12'(k)), got, words[k]);
    end
    check_value("err", 32'(err), 32'(exp_err));
  endtask

  task automatic read_test(input logic [AWIDTH-1:0] haddr, input logic [MEMSIZE-1:0] base,
                           input logic [2:0] exp_err, input bit toggle);
    logic [31:0] words [BURST_LEN];
    logic [31:0] got;
    for (int k = 0; k < BURST_LEN; k++) begin
      words[k] = rand_bits(32);
      load_host(haddr[13:2] + 12'(k), words[k]);
    end
    run_burst(DDR_READ, haddr, base, toggle);
    for (int k = 0; k < BURST_LEN; k++) begin
      read_buffer(base + MEMSIZE'(k), got);
      check_value($sformatf("ext_rdata[%0d]", base + MEMSIZE'(k)), got, words[k]);
    end
    check_value("err", 32'(err), 32'(exp_err));
  endtask

  task automatic end_test(input string name, input int errors_before, input int fails_before);
    int bad;
    bad = errors - errors_before + assert_fails - fails_before;
    tests++;
    if (bad == 0) begin
      $display("test %-20s pass", name);
    end else begin
      $display("test %-20s FAIL, %0d errors", name, bad);
      failed_tests++;
    end
  endtask

  // ========================================
  // test sequence
  // ========================================

  initial begin
    int e0;
    int a0;
    int aw0;
    int ar0;
    int n;
    req          = 1'b0;
    mode         = DDR_READ;
    host_addr    = '0;
    buf_base     = '0;
    ext_we       = 1'b0;
    ext_addr     = '0;
    ext_wdata    = '0;
    stall_en     = 1'b0;
    wr_err       = 1'b0;
    rd_err_en    = 1'b0;
    rd_err_beat  = '0;
    load_we      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    peek_addr    = '0;
    lfsr         = 32'd41;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    n = 0;
    while (xrst !== 1'b1 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (xrst !== 1'b1) begin
      $display("Timeout: reset was never released");
      errors++;
    end
    // known background for the untouched-region check
    for (int i = 0; i < 4096; i++) begin
      load_host(12'(i), fill_word(12'(i)));
    end

    e0 = errors;
    a0 = assert_fails;
    write_test(32'h0000_0100, 10'h010, 3'b000, 1'b0);
    end_test("write burst", e0, a0);

    e0 = errors;
    a0 = assert_fails;
    read_test(32'h0000_0400, 10'h080, 3'b000, 1'b0);
    end_test("read burst", e0, a0);

    e0 = errors;
    a0 = assert_fails;
    stall_en = 1'b1;
    write_test(32'h0000_0800, 10'h100, 3'b000, 1'b0);
    read_test(32'h0000_0c00, 10'h180, 3'b000, 1'b0);
    stall_en = 1'b0;
    end_test("back-pressure", e0, a0);

    e0 = errors;
    a0 = assert_fails;
    wr_err = 1'b1;
    write_test(32'h0000_1000, 10'h200, 3'((1 << ERR_WRESP) | (1 << ERR_ANY)), 1'b0);
    wr_err      = 1'b0;
    rd_err_en   = 1'b1;
    rd_err_beat = BEAT_WIDTH'(rand_bits(BEAT_WIDTH));
    read_test(32'h0000_1400, 10'h280, 3'((1 << ERR_RRESP) | (1 << ERR_ANY)), 1'b0);
    rd_err_en = 1'b0;
    // a clean request clears the flags
    write_test(32'h0000_1800, 10'h300, 3'b000, 1'b0);
    end_test("error flags", e0, a0);

    e0 = errors;
    a0 = assert_fails;
    aw0 = aw_count;
    ar0 = ar_count;
    write_test(32'h0000_2000, 10'h340, 3'b000, 1'b1);
    check_value("aw handshakes", 32'(aw_count), 32'(aw0 + 1));
    for (int k = 1; k <= BURST_LEN; k++) begin
      check_untouched(12'h800 - 12'(k));
      check_untouched(12'h80f + 12'(k));
    end
    read_test(32'h0000_2400, 10'h3a0, 3'b000, 1'b1);
    check_value("ar handshakes", 32'(ar_count), 32'(ar0 + 1));
    end_test("busy and ignored req", e0, a0);

    $display("tests %0d, failed tests %0d, failed checks %0d, assertion failures %0d",
             tests, failed_tests, errors, assert_fails);
    if (failed_tests == 0 && errors == 0 && assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
